/* source/axi_atop_pkg.sv */
// Bus widths, memory geometry and outstanding-burst limit for the subsystem
// AXI channel structs, request and response bundles, and the response enums
package axi_atop_pkg;

  // Bus widths
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned AddrWidth = 8;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // Memory depth in words, the word index comes from address bits [5:2]
  localparam int unsigned MemWords     = 16;
  localparam int unsigned WordLsb      = 2;
  localparam int unsigned WordIdxWidth = $clog2(MemWords);

  // Most write bursts the filter lets be in flight downstream
  localparam int unsigned MaxWriteTxns = 2;

  typedef logic [IdWidth-1:0]      id_t;
  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [StrbWidth-1:0]    strb_t;
  typedef logic [WordIdxWidth-1:0] word_idx_t;
  // A burst carries len+1 beats
  typedef logic [7:0]              len_t;
  typedef logic [5:0]              atop_t;

  // Decode of atop[5:4], every kind other than NONE is atomic
  typedef enum logic [1:0] {
    ATOP_NONE        = 2'b00,
    ATOP_ATOMICSTORE = 2'b01,
    ATOP_ATOMICLOAD  = 2'b10,
    ATOP_ATOMICCMP   = 2'b11
  } atop_kind_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
    atop_t atop;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_e resp;
  } b_chan_t;

  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } ar_chan_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_e resp;
    logic  last;
  } r_chan_t;

  // Everything the master drives
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // Everything the slave drives
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } axi_resp_t;

  // Command from the filter's write side to its read side
  typedef struct packed {
    len_t len;
  } r_cmd_t;

endpackage

/* source/stream_register.sv */
// One-slot valid/ready register for an arbitrary payload type
module stream_register #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  logic full_q;
  T     data_q;
  logic push;
  logic pop;

  // Ready when empty, or when the held entry leaves in this same cycle
  assign pop     = full_q & ready_i;
  assign ready_o = ~full_q | ready_i;
  assign push    = valid_i & ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (push) begin
      full_q <= 1'b1;
    end else if (pop) begin
      full_q <= 1'b0;
    end
  end

  // Payload only changes on a push, so data_o is stable until popped
  always_ff @(posedge clk_i) begin
    if (push) begin
      data_q <= data_i;
    end
  end

  assign valid_o = full_q;
  assign data_o  = data_q;

endmodule

/* source/atop_filter.sv */
// Atomic-operation filter between one AXI master and a slave without atomics
// Forwards ordinary traffic and answers atomic writes with SLVERR B and R responses
module atop_filter import axi_atop_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  axi_req_t  slv_req_i,
  output axi_resp_t slv_resp_o,
  output axi_req_t  mst_req_o,
  input  axi_resp_t mst_resp_i
);

  typedef logic [$clog2(MaxWriteTxns+1)-1:0] w_cnt_t;

  typedef enum logic [2:0] {
    W_FEEDTHROUGH,
    BLOCK_AW,
    ABSORB_W,
    INJECT_B,
    WAIT_R
  } w_state_e;

  typedef enum logic {
    R_FEEDTHROUGH,
    INJECT_R
  } r_state_e;

  w_state_e   w_state_d, w_state_q;
  r_state_e   r_state_d, r_state_q;
  w_cnt_t     w_cnt_d, w_cnt_q;
  id_t        id_d, id_q;
  len_t       r_beats_d, r_beats_q;
  logic       r_fwd_busy_d, r_fwd_busy_q;
  atop_kind_e aw_kind;
  logic       aw_needs_r;
  logic       inject_last;
  logic       fwd_r_hs;
  r_cmd_t     r_cmd_push, r_cmd_pop;
  logic       r_cmd_push_valid;
  logic       r_cmd_pop_valid, r_cmd_pop_ready;

  assign aw_kind    = atop_kind_e'(slv_req_i.aw.atop[5:4]);
  // Every atomic kind except atomic store also returns read data
  assign aw_needs_r = (aw_kind == ATOP_ATOMICLOAD) || (aw_kind == ATOP_ATOMICCMP);
  assign r_cmd_push.len = slv_req_i.aw.len;

  // AW, W and B channels
  always_comb begin
    mst_req_o.aw        = slv_req_i.aw;
    mst_req_o.aw.atop   = '0;
    mst_req_o.w         = slv_req_i.w;
    mst_req_o.aw_valid  = 1'b0;
    slv_resp_o.aw_ready = 1'b0;
    mst_req_o.w_valid   = 1'b0;
    slv_resp_o.w_ready  = 1'b0;
    // Write responses pass through unless one is being injected
    mst_req_o.b_ready   = slv_req_i.b_ready;
    slv_resp_o.b_valid  = mst_resp_i.b_valid;
    slv_resp_o.b        = mst_resp_i.b;
    id_d                = id_q;
    r_cmd_push_valid    = 1'b0;
    w_state_d           = w_state_q;

    unique case (w_state_q)
      W_FEEDTHROUGH: begin
        if (w_cnt_q < w_cnt_t'(MaxWriteTxns)) begin
          mst_req_o.aw_valid  = slv_req_i.aw_valid;
          slv_resp_o.aw_ready = mst_resp_i.aw_ready;
        end
        // W beats only follow an AW that has already gone downstream
        if (w_cnt_q != '0) begin
          mst_req_o.w_valid  = slv_req_i.w_valid;
          slv_resp_o.w_ready = mst_resp_i.w_ready;
        end
        if (slv_req_i.aw_valid && aw_kind != ATOP_NONE) begin
          // Atomic AW never reaches the memory
          // The command slot is always empty in this state and the AW is taken at once
          mst_req_o.aw_valid  = 1'b0;
          slv_resp_o.aw_ready = 1'b1;
          id_d                = slv_req_i.aw.id;
          r_cmd_push_valid    = aw_needs_r;
          if (w_cnt_q != '0) begin
            // Let the bursts already downstream finish their W beats first
            w_state_d = BLOCK_AW;
          end else begin
            mst_req_o.w_valid  = 1'b0;
            slv_resp_o.w_ready = 1'b1;
            if (slv_req_i.w_valid && slv_req_i.w.last) begin
              w_state_d = INJECT_B;
            end else begin
              w_state_d = ABSORB_W;
            end
          end
        end
      end

      BLOCK_AW: begin
        if (w_cnt_q != '0) begin
          mst_req_o.w_valid  = slv_req_i.w_valid;
          slv_resp_o.w_ready = mst_resp_i.w_ready;
        end else begin
          // Now the W beats on the port belong to the atomic burst
          slv_resp_o.w_ready = 1'b1;
          if (slv_req_i.w_valid && slv_req_i.w.last) begin
            w_state_d = INJECT_B;
          end else begin
            w_state_d = ABSORB_W;
          end
        end
      end

      ABSORB_W: begin
        slv_resp_o.w_ready = 1'b1;
        if (slv_req_i.w_valid && slv_req_i.w.last) begin
          w_state_d = INJECT_B;
        end
      end

      INJECT_B: begin
        // Hold any downstream B while the error response is shown
        mst_req_o.b_ready  = 1'b0;
        slv_resp_o.b       = '0;
        slv_resp_o.b.id    = id_q;
        slv_resp_o.b.resp  = RESP_SLVERR;
        slv_resp_o.b_valid = 1'b1;
        if (slv_req_i.b_ready) begin
          if (r_cmd_pop_valid && !r_cmd_pop_ready) begin
            w_state_d = WAIT_R;
          end else begin
            w_state_d = W_FEEDTHROUGH;
          end
        end
      end

      WAIT_R: begin
        // The command is popped with the last injected R beat
        if (!r_cmd_pop_valid) begin
          w_state_d = W_FEEDTHROUGH;
        end
      end

      default: begin
        w_state_d = W_FEEDTHROUGH;
      end
    endcase
  end

  // Outstanding downstream write bursts, counted from AW to last W
  always_comb begin
    w_cnt_d = w_cnt_q;
    if (mst_req_o.aw_valid && mst_resp_i.aw_ready) begin
      w_cnt_d = w_cnt_d + w_cnt_t'(1);
    end
    if (mst_req_o.w_valid && mst_resp_i.w_ready && mst_req_o.w.last) begin
      w_cnt_d = w_cnt_d - w_cnt_t'(1);
    end
  end

  assign inject_last = (r_beats_q == '0);
  assign fwd_r_hs    = mst_resp_i.r_valid && mst_req_o.r_ready;

  // AR and R channels
  always_comb begin
    mst_req_o.ar        = slv_req_i.ar;
    mst_req_o.ar_valid  = slv_req_i.ar_valid;
    slv_resp_o.ar_ready = mst_resp_i.ar_ready;
    slv_resp_o.r        = mst_resp_i.r;
    slv_resp_o.r_valid  = mst_resp_i.r_valid;
    mst_req_o.r_ready   = slv_req_i.r_ready;
    r_cmd_pop_ready     = 1'b0;
    r_beats_d           = r_beats_q;
    r_state_d           = r_state_q;

    unique case (r_state_q)
      R_FEEDTHROUGH: begin
        // Inject only between whole forwarded bursts with no beat on offer
        if (r_cmd_pop_valid && !r_fwd_busy_q && !mst_resp_i.r_valid) begin
          r_beats_d = r_cmd_pop.len;
          r_state_d = INJECT_R;
        end
      end

      INJECT_R: begin
        mst_req_o.r_ready  = 1'b0;
        slv_resp_o.r       = '0;
        slv_resp_o.r.id    = id_q;
        slv_resp_o.r.resp  = RESP_SLVERR;
        slv_resp_o.r.last  = inject_last;
        slv_resp_o.r_valid = 1'b1;
        if (slv_req_i.r_ready) begin
          if (inject_last) begin
            r_cmd_pop_ready = 1'b1;
            r_state_d       = R_FEEDTHROUGH;
          end else begin
            r_beats_d = r_beats_q - len_t'(1);
          end
        end
      end

      default: begin
        r_state_d = R_FEEDTHROUGH;
      end
    endcase
  end

  // Set while a forwarded read burst is between its first and last beat
  always_comb begin
    r_fwd_busy_d = r_fwd_busy_q;
    if (fwd_r_hs) begin
      r_fwd_busy_d = !mst_resp_i.r.last;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_state_q    <= W_FEEDTHROUGH;
      r_state_q    <= R_FEEDTHROUGH;
      w_cnt_q      <= '0;
      r_beats_q    <= '0;
      r_fwd_busy_q <= 1'b0;
    end else begin
      w_state_q    <= w_state_d;
      r_state_q    <= r_state_d;
      w_cnt_q      <= w_cnt_d;
      r_beats_q    <= r_beats_d;
      r_fwd_busy_q <= r_fwd_busy_d;
    end
  end

  // ID of the atomic write, shared by its B and R responses
  always_ff @(posedge clk_i) begin
    id_q <= id_d;
  end

  stream_register #(
    .T(r_cmd_t)
  ) u_r_cmd_reg (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (r_cmd_push_valid),
    .ready_o (),
    .data_i  (r_cmd_push),
    .valid_o (r_cmd_pop_valid),
    .ready_i (r_cmd_pop_ready),
    .data_o  (r_cmd_pop)
  );

endmodule

/* source/axi_sram_slave.sv */
// Word-addressed AXI memory slave with INCR bursts and byte strobes
// One write burst and one read burst at a time, running independently
module axi_sram_slave import axi_atop_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  axi_req_t  req_i,
  output axi_resp_t resp_o
);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  typedef enum logic {
    RD_IDLE,
    RD_DATA
  } rd_state_e;

  wr_state_e wr_state_q, wr_state_d;
  rd_state_e rd_state_q, rd_state_d;
  data_t     mem_q [MemWords];
  id_t       wr_id_q;
  word_idx_t wr_idx_q;
  id_t       rd_id_q;
  word_idx_t rd_idx_q;
  len_t      rd_cnt_q;
  logic      aw_hs;
  logic      w_hs;
  logic      ar_hs;
  logic      r_hs;

  assign aw_hs = req_i.aw_valid && resp_o.aw_ready;
  assign w_hs  = req_i.w_valid && resp_o.w_ready;
  assign ar_hs = req_i.ar_valid && resp_o.ar_ready;
  assign r_hs  = resp_o.r_valid && req_i.r_ready;

  // Write side, AW is taken only when no burst is in progress
  always_comb begin
    resp_o.aw_ready = (wr_state_q == WR_IDLE);
    resp_o.w_ready  = (wr_state_q == WR_DATA);
    resp_o.b_valid  = (wr_state_q == WR_RESP);
    resp_o.b.id     = wr_id_q;
    resp_o.b.resp   = RESP_OKAY;
    wr_state_d      = wr_state_q;
    unique case (wr_state_q)
      WR_IDLE: if (aw_hs) wr_state_d = WR_DATA;
      WR_DATA: if (w_hs && req_i.w.last) wr_state_d = WR_RESP;
      WR_RESP: if (req_i.b_ready) wr_state_d = WR_IDLE;
      default: wr_state_d = WR_IDLE;
    endcase
  end

  // Read side, the first beat is on offer the cycle after AR
  always_comb begin
    resp_o.ar_ready = (rd_state_q == RD_IDLE);
    resp_o.r_valid  = (rd_state_q == RD_DATA);
    resp_o.r.id     = rd_id_q;
    resp_o.r.data   = mem_q[rd_idx_q];
    resp_o.r.resp   = RESP_OKAY;
    resp_o.r.last   = (rd_cnt_q == '0);
    rd_state_d      = rd_state_q;
    unique case (rd_state_q)
      RD_IDLE: if (ar_hs) rd_state_d = RD_DATA;
      RD_DATA: if (r_hs && resp_o.r.last) rd_state_d = RD_IDLE;
      default: rd_state_d = RD_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_state_q <= WR_IDLE;
      rd_state_q <= RD_IDLE;
    end else begin
      wr_state_q <= wr_state_d;
      rd_state_q <= rd_state_d;
    end
  end

  // Burst bookkeeping, word indices wrap modulo MemWords by their width
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      wr_id_q  <= req_i.aw.id;
      wr_idx_q <= req_i.aw.addr[WordLsb +: WordIdxWidth];
    end else if (w_hs) begin
      wr_idx_q <= wr_idx_q + word_idx_t'(1);
    end
    if (ar_hs) begin
      rd_id_q  <= req_i.ar.id;
      rd_idx_q <= req_i.ar.addr[WordLsb +: WordIdxWidth];
      rd_cnt_q <= req_i.ar.len;
    end else if (r_hs) begin
      rd_idx_q <= rd_idx_q + word_idx_t'(1);
      rd_cnt_q <= rd_cnt_q - len_t'(1);
    end
  end

  // Storage, only strobed byte lanes of each W beat are written
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < MemWords; i++) begin
        mem_q[i] <= '0;
      end
    end else if (w_hs) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (req_i.w.strb[b]) begin
          mem_q[wr_idx_q][8*b +: 8] <= req_i.w.data[8*b +: 8];
        end
      end
    end
  end

endmodule

/* source/atop_subsys_top.sv */
// Subsystem top level with the atomic filter in front of the memory slave
module atop_subsys_top import axi_atop_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  axi_req_t  slv_req_i,
  output axi_resp_t slv_resp_o
);

  // Filtered bus toward the memory, never carrying a non-zero atop
  axi_req_t  mem_req;
  axi_resp_t mem_resp;

  atop_filter u_atop_filter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .slv_req_i  (slv_req_i),
    .slv_resp_o (slv_resp_o),
    .mst_req_o  (mem_req),
    .mst_resp_i (mem_resp)
  );

  axi_sram_slave u_sram (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (mem_req),
    .resp_o (mem_resp)
  );

endmodule

/* tb/tb_atop_tasks.svh */
// AXI channel driver tasks and response wait for the subsystem testbench
// Compare tasks for B beats, R beats and beat counts
`ifndef TB_ATOP_TASKS_SVH
`define TB_ATOP_TASKS_SVH

// Each driver raises valid, then holds the payload until ready is seen before an edge
task automatic send_aw(input aw_chan_t aw);
  logic taken;
  taken = 1'b0;
  axi_req.aw = aw;
  axi_req.aw_valid = 1'b1;
  while (!taken) begin
    @(negedge clk_i);
    taken = axi_resp.aw_ready;
    @(posedge clk_i);
    #DriveDelay;
  end
  axi_req.aw_valid = 1'b0;
endtask

task automatic send_w(input w_chan_t w);
  logic taken;
  taken = 1'b0;
  axi_req.w = w;
  axi_req.w_valid = 1'b1;
  while (!taken) begin
    @(negedge clk_i);
    taken = axi_resp.w_ready;
    @(posedge clk_i);
    #DriveDelay;
  end
  axi_req.w_valid = 1'b0;
endtask

task automatic send_ar(input ar_chan_t ar);
  logic taken;
  taken = 1'b0;
  axi_req.ar = ar;
  axi_req.ar_valid = 1'b1;
  while (!taken) begin
    @(negedge clk_i);
    taken = axi_resp.ar_ready;
    @(posedge clk_i);
    #DriveDelay;
  end
  axi_req.ar_valid = 1'b0;
endtask

// Waits for the monitors to collect the expected beats, then lets the bus settle
// so that any extra beat would also land in the queues
task automatic wait_responses(input int nb, input int nr);
  while (b_seen.size() < nb || r_seen.size() < nr) begin
    @(posedge clk_i);
    #DriveDelay;
  end
  repeat (SettleCycles) @(posedge clk_i);
  #DriveDelay;
endtask

task automatic check_b(input b_chan_t got, input b_chan_t exp);
  if (got !== exp) begin
    abort_run($sformatf("CHECK FAILED slv_resp_o.b got id=%h resp=%h expected id=%h resp=%h",
                        got.id, got.resp, exp.id, exp.resp));
  end
endtask

task automatic check_r(input r_chan_t got, input r_chan_t exp);
  if (got !== exp) begin
    abort_run($sformatf({"CHECK FAILED slv_resp_o.r got id=%h data=%h resp=%h last=%h",
                         " expected id=%h data=%h resp=%h last=%h"},
                        got.id, got.data, got.resp, got.last,
                        exp.id, exp.data, exp.resp, exp.last));
  end
endtask

task automatic check_count(input string name, input int got, input int exp);
  if (got !== exp) begin
    abort_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  end
endtask

`endif

/* tb/tb_atop_subsys.sv */
// Testbench for the atomic filter subsystem with a stimulus table and a reference memory
// Runs the table twice, the second time with random B and R back-pressure
module tb_atop_subsys import axi_atop_pkg::*; ;

  localparam int DriveDelay    = 2;
  localparam int ResetCycles   = 10;
  localparam int SettleCycles  = 4;
  localparam int NumOps        = 11;
  localparam int NumPasses     = 2;
  localparam int TimeoutCycles = 40 * NumOps * NumPasses + ResetCycles;

  typedef enum logic {
    OP_WRITE,
    OP_READ
  } op_kind_e;

  typedef struct packed {
    op_kind_e kind;
    id_t      id;
    addr_t    addr;
    len_t     len;
    atop_t    atop;
    data_t    seed;
    strb_t    strb;
  } op_t;

  logic      clk_i;
  logic      rst_ni;
  axi_req_t  axi_req;
  axi_resp_t axi_resp;
  logic      stall_en;
  integer    seed = 32'hac52_fbf9;
  int        cycles;
  int        errors;
  op_t       ops [NumOps];
  data_t     ref_mem [MemWords];
  b_chan_t   b_seen [$];
  r_chan_t   r_seen [$];

  atop_subsys_top u_dut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .slv_req_i  (axi_req),
    .slv_resp_o (axi_resp)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Prints the reason and ends the run at the first error
  task automatic abort_run(input string what);
    errors++;
    $display("%s", what);
    $display("Errors found");
    $fatal(1, "Run stopped at the first error");
  endtask

  `include "tb_atop_tasks.svh"

  function automatic op_t make_op(input op_kind_e kind, input id_t id, input addr_t addr,
                                  input len_t len, input atop_t atop, input data_t seed_word,
                                  input strb_t strb);
    op_t op;
    op.kind = kind;
    op.id   = id;
    op.addr = addr;
    op.len  = len;
    op.atop = atop;
    op.seed = seed_word;
    op.strb = strb;
    return op;
  endfunction

  // Each beat of a write burst gets its own word derived from the entry's seed
  function automatic data_t beat_data(input data_t seed_word, input int beat);
    return seed_word + data_t'(beat) * 32'h1111_1111;
  endfunction

  // Word index of a beat, wrapping modulo the memory depth
  function automatic int word_of(input addr_t addr, input int beat);
    return (int'(addr) / 4 + beat) % MemWords;
  endfunction

  task automatic run_write(input op_t op);
    aw_chan_t aw;
    w_chan_t  w;
    b_chan_t  exp_b;
    r_chan_t  exp_r;
    int       nr;
    int       idx;
    aw.id   = op.id;
    aw.addr = op.addr;
    aw.len  = op.len;
    aw.atop = op.atop;
    // Only load and compare kinds return an R burst
    nr = (op.atop[5:4] > ATOP_ATOMICSTORE) ? int'(op.len) + 1 : 0;
    send_aw(aw);
    for (int i = 0; i <= int'(op.len); i++) begin
      w.data = beat_data(op.seed, i);
      w.strb = op.strb;
      w.last = (i == int'(op.len));
      send_w(w);
      // The reference memory only sees ordinary writes, lane by lane
      if (op.atop[5:4] == ATOP_NONE) begin
        idx = word_of(op.addr, i);
        for (int b = 0; b < StrbWidth; b++) begin
          if (op.strb[b]) ref_mem[idx][8*b +: 8] = w.data[8*b +: 8];
        end
      end
    end
    wait_responses(1, nr);
    check_count("b beat count", b_seen.size(), 1);
    check_count("r beat count", r_seen.size(), nr);
    exp_b.id   = op.id;
    exp_b.resp = (op.atop[5:4] == ATOP_NONE) ? RESP_OKAY : RESP_SLVERR;
    check_b(b_seen.pop_front(), exp_b);
    for (int i = 0; i < nr; i++) begin
      exp_r.id   = op.id;
      exp_r.data = '0;
      exp_r.resp = RESP_SLVERR;
      exp_r.last = (i == nr - 1);
      check_r(r_seen.pop_front(), exp_r);
    end
  endtask

  task automatic run_read(input op_t op);
    ar_chan_t ar;
    r_chan_t  exp_r;
    int       nr;
    ar.id   = op.id;
    ar.addr = op.addr;
    ar.len  = op.len;
    nr = int'(op.len) + 1;
    send_ar(ar);
    wait_responses(0, nr);
    check_count("b beat count", b_seen.size(), 0);
    check_count("r beat count", r_seen.size(), nr);
    for (int i = 0; i < nr; i++) begin
      exp_r.id   = op.id;
      exp_r.data = ref_mem[word_of(op.addr, i)];
      exp_r.resp = RESP_OKAY;
      exp_r.last = (i == nr - 1);
      check_r(r_seen.pop_front(), exp_r);
    end
  endtask

  // Handshakes are decided at the falling edge, where every signal is settled
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (axi_resp.b_valid && axi_req.b_ready) b_seen.push_back(axi_resp.b);
      if (axi_resp.r_valid && axi_req.r_ready) r_seen.push_back(axi_resp.r);
    end
  end

  // Random B and R back-pressure in the second pass
  always @(posedge clk_i) begin
    logic [31:0] rnd;
    #DriveDelay;
    rnd = $random(seed);
    axi_req.b_ready = stall_en ? rnd[0] : 1'b1;
    axi_req.r_ready = stall_en ? rnd[1] : 1'b1;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= TimeoutCycles) begin
      abort_run($sformatf("Timeout: the stimulus table did not finish within %0d cycles",
                          TimeoutCycles));
    end
  end

  initial begin
    axi_req  = '0;
    rst_ni   = 1'b0;
    stall_en = 1'b0;
    cycles   = 0;
    errors   = 0;
    for (int i = 0; i < MemWords; i++) ref_mem[i] = '0;
    // Single write, full and partial bursts wrapping past the top word
    ops[0]  = make_op(OP_WRITE, 4'h3, 8'h10, 8'd0, 6'h00, 32'hdead_beef, 4'hf);
    ops[1]  = make_op(OP_READ,  4'h3, 8'h10, 8'd0, 6'h00, 32'h0, 4'h0);
    ops[2]  = make_op(OP_WRITE, 4'h5, 8'h38, 8'd3, 6'h00, 32'ha5a5_0f0f, 4'hf);
    ops[3]  = make_op(OP_WRITE, 4'h6, 8'h38, 8'd3, 6'h00, 32'h1234_5678, 4'h6);
    ops[4]  = make_op(OP_READ,  4'h6, 8'h38, 8'd3, 6'h00, 32'h0, 4'h0);
    // Atomic store, load and compare, each followed by a read of the same words
    ops[5]  = make_op(OP_WRITE, 4'h9, 8'h10, 8'd0, 6'h10, 32'hffff_ffff, 4'hf);
    ops[6]  = make_op(OP_READ,  4'h9, 8'h10, 8'd0, 6'h00, 32'h0, 4'h0);
    ops[7]  = make_op(OP_WRITE, 4'hc, 8'h38, 8'd2, 6'h20, 32'h5555_aaaa, 4'hf);
    ops[8]  = make_op(OP_READ,  4'hc, 8'h38, 8'd3, 6'h00, 32'h0, 4'h0);
    ops[9]  = make_op(OP_WRITE, 4'ha, 8'h04, 8'd1, 6'h31, 32'h0bad_f00d, 4'hf);
    ops[10] = make_op(OP_READ,  4'ha, 8'h00, 8'd3, 6'h00, 32'h0, 4'h0);
    repeat (ResetCycles) @(posedge clk_i);
    #DriveDelay;
    rst_ni = 1'b1;
    for (int pass = 0; pass < NumPasses; pass++) begin
      stall_en = (pass == 1);
      for (int i = 0; i < NumOps; i++) begin
        if (ops[i].kind == OP_WRITE) run_write(ops[i]);
        else run_read(ops[i]);
      end
    end
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+tb
source/axi_atop_pkg.sv
source/stream_register.sv
source/atop_filter.sv
source/axi_sram_slave.sv
source/atop_subsys_top.sv
tb/tb_atop_subsys.sv
